// ==== logic/bench_if.sv ====
`timescale 1ns/1ps

// capture stage to decode stage and run control
// all strobes last one cycle, fields valid only with their strobe
interface tcp_event_if #(
  parameter int stream_bytes = bench_pkg::default_stream_bytes
);
  logic                       start_edge;  // ap_start rose
  logic                       rx_fire;     // rx beat accepted
  logic                       rx_last;
  logic [stream_bytes-1:0]    rx_keep;
  logic                       tx_fire;     // tx beat accepted
  logic                       tx_last;
  logic [stream_bytes-1:0]    tx_keep;
  logic                       sts_fire;    // tx status word accepted
  bench_pkg::tx_status_t      sts_word;
  logic                       open_fire;   // open status word accepted
  bench_pkg::open_status_t    open_word;
  logic                       close_fire;  // close request accepted

  modport src (
    output start_edge, rx_fire, rx_last, rx_keep, tx_fire, tx_last, tx_keep,
    output sts_fire, sts_word, open_fire, open_word, close_fire
  );
  modport dst (
    input start_edge, rx_fire, rx_last, rx_keep, tx_fire, tx_last, tx_keep,
    input sts_fire, sts_word, open_fire, open_word, close_fire
  );
endinterface

// decode stage to accumulator, per-cycle increments
interface tcp_delta_if #(
  parameter int stream_bytes = bench_pkg::default_stream_bytes
);
  localparam int cnt_w = $clog2(stream_bytes + 1);  // holds 0..stream_bytes

  logic             clear;          // restart, load instead of add
  logic [cnt_w-1:0] rx_bytes_inc;
  logic             rx_pkt_inc;
  logic [cnt_w-1:0] tx_bytes_inc;
  logic             tx_pkt_inc;
  logic             sts_inc;
  logic             sts_good_inc;
  logic             open_inc;
  logic             open_good_inc;

  modport src (
    output clear, rx_bytes_inc, rx_pkt_inc, tx_bytes_inc, tx_pkt_inc,
    output sts_inc, sts_good_inc, open_inc, open_good_inc
  );
  modport dst (
    input clear, rx_bytes_inc, rx_pkt_inc, tx_bytes_inc, tx_pkt_inc,
    input sts_inc, sts_good_inc, open_inc, open_good_inc
  );
endinterface

// ==== logic/bench_monitor_top.sv ====
`timescale 1ns/1ps

// benchmark statistics monitor, watches client and offload stack handshakes
module bench_monitor_top #(
  parameter int stream_bytes = bench_pkg::default_stream_bytes
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    ap_start,
  input  logic                    rx_tvalid,
  input  logic                    rx_tready,
  input  logic [stream_bytes-1:0] rx_tkeep,
  input  logic                    rx_tlast,
  input  logic                    tx_tvalid,
  input  logic                    tx_tready,
  input  logic [stream_bytes-1:0] tx_tkeep,
  input  logic                    tx_tlast,
  input  logic                    tx_status_tvalid,
  input  logic                    tx_status_tready,
  input  bench_pkg::tx_status_t   tx_status_tdata,
  input  logic                    open_status_tvalid,
  input  logic                    open_status_tready,
  input  bench_pkg::open_status_t open_status_tdata,
  input  logic                    close_tvalid,
  input  logic                    close_tready,
  output logic                    ap_done,
  output logic                    ap_idle,
  output bench_pkg::byte_cnt_t    rx_bytes,
  output bench_pkg::byte_cnt_t    tx_bytes,
  output bench_pkg::stat_cnt_t    rx_pkts,
  output bench_pkg::stat_cnt_t    tx_pkts,
  output bench_pkg::stat_cnt_t    sts_total,
  output bench_pkg::stat_cnt_t    sts_good,
  output bench_pkg::stat_cnt_t    open_total,
  output bench_pkg::stat_cnt_t    open_good,
  output bench_pkg::cycle_cnt_t   exec_cycles
);

  tcp_event_if #(.stream_bytes(stream_bytes)) ev ();  // capture -> decode, run control
  tcp_delta_if #(.stream_bytes(stream_bytes)) dl ();  // decode -> accumulate

  event_capture #(.stream_bytes(stream_bytes)) i_event_capture (
    .ap_clk, .ap_rst_n, .ap_start,
    .rx_tvalid, .rx_tready, .rx_tkeep, .rx_tlast,
    .tx_tvalid, .tx_tready, .tx_tkeep, .tx_tlast,
    .tx_status_tvalid, .tx_status_tready, .tx_status_tdata,
    .open_status_tvalid, .open_status_tready, .open_status_tdata,
    .close_tvalid, .close_tready,
    .ev (ev.src)
  );

  keep_decode #(.stream_bytes(stream_bytes)) i_keep_decode (
    .ap_clk, .ap_rst_n,
    .ev (ev.dst),
    .dl (dl.src)
  );

  stat_accumulate i_stat_accumulate (
    .ap_clk, .ap_rst_n,
    .dl (dl.dst),
    .rx_bytes, .tx_bytes, .rx_pkts, .tx_pkts,
    .sts_total, .sts_good, .open_total, .open_good
  );

  run_control i_run_control (
    .ap_clk, .ap_rst_n,
    .ev (ev.dst),
    .ap_done, .ap_idle, .exec_cycles
  );

endmodule

// ==== logic/bench_pkg.sv ====
package bench_pkg;

  // counter widths, sized for long experiment windows
  typedef logic [41:0] byte_cnt_t;   // byte totals, 4 TB before wrap
  typedef logic [31:0] stat_cnt_t;   // packet and status word totals
  typedef logic [63:0] cycle_cnt_t;  // execution cycles

  // status words from the offload stack
  typedef logic [63:0] tx_status_t;
  typedef logic [23:0] open_status_t;

  // data stream width in bytes, top level may override
  parameter int default_stream_bytes = 8;

  // tx status error field, all zero when the write went through
  parameter int tx_err_hi = 63;
  parameter int tx_err_lo = 62;

  // open status, set when the connection came up
  parameter int open_success_bit = 16;

endpackage

// ==== logic/event_capture.sv ====
`timescale 1ns/1ps

// stage 1: samples every handshake once per edge, pure monitor
module event_capture #(
  parameter int stream_bytes = bench_pkg::default_stream_bytes
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    ap_start,
  input  logic                    rx_tvalid,
  input  logic                    rx_tready,
  input  logic [stream_bytes-1:0] rx_tkeep,
  input  logic                    rx_tlast,
  input  logic                    tx_tvalid,
  input  logic                    tx_tready,
  input  logic [stream_bytes-1:0] tx_tkeep,
  input  logic                    tx_tlast,
  input  logic                    tx_status_tvalid,
  input  logic                    tx_status_tready,
  input  bench_pkg::tx_status_t   tx_status_tdata,
  input  logic                    open_status_tvalid,
  input  logic                    open_status_tready,
  input  bench_pkg::open_status_t open_status_tdata,
  input  logic                    close_tvalid,
  input  logic                    close_tready,
  tcp_event_if.src                ev
);

  logic start_q;  // ap_start one edge ago

  // strobes and the start history
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q       <= 1'b0;
      ev.start_edge <= 1'b0;
      ev.rx_fire    <= 1'b0;
      ev.tx_fire    <= 1'b0;
      ev.sts_fire   <= 1'b0;
      ev.open_fire  <= 1'b0;
      ev.close_fire <= 1'b0;
    end else begin
      start_q       <= ap_start;
      ev.start_edge <= ap_start & ~start_q;  // rising level only
      ev.rx_fire    <= rx_tvalid & rx_tready;
      ev.tx_fire    <= tx_tvalid & tx_tready;
      ev.sts_fire   <= tx_status_tvalid & tx_status_tready;
      ev.open_fire  <= open_status_tvalid & open_status_tready;
      ev.close_fire <= close_tvalid & close_tready;
    end
  end

  // payload fields ride along with the strobes, meaningless otherwise
  always_ff @(posedge ap_clk) begin
    ev.rx_keep   <= rx_tkeep;
    ev.rx_last   <= rx_tlast;
    ev.tx_keep   <= tx_tkeep;
    ev.tx_last   <= tx_tlast;
    ev.sts_word  <= tx_status_tdata;
    ev.open_word <= open_status_tdata;
  end

endmodule

// ==== logic/keep_decode.sv ====
`timescale 1ns/1ps

// stage 2: turns captured events into counter increments
module keep_decode #(
  parameter int stream_bytes = bench_pkg::default_stream_bytes
) (
  input  logic     ap_clk,
  input  logic     ap_rst_n,
  tcp_event_if.dst ev,
  tcp_delta_if.src dl
);

  localparam int cnt_w = $clog2(stream_bytes + 1);

  // bytes in a beat are the set keep bits, holes included
  function automatic logic [cnt_w-1:0] keep_bytes(input logic [stream_bytes-1:0] keep);
    logic [cnt_w-1:0] n;
    n = '0;
    for (int i = 0; i < stream_bytes; i++) begin
      n = n + cnt_w'(keep[i]);
    end
    return n;
  endfunction

  logic sts_ok;   // error field clear
  logic open_ok;  // connection opened

  assign sts_ok  = ev.sts_word[bench_pkg::tx_err_hi:bench_pkg::tx_err_lo] == '0;
  assign open_ok = ev.open_word[bench_pkg::open_success_bit];

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      dl.clear         <= 1'b0;
      dl.rx_bytes_inc  <= '0;
      dl.rx_pkt_inc    <= 1'b0;
      dl.tx_bytes_inc  <= '0;
      dl.tx_pkt_inc    <= 1'b0;
      dl.sts_inc       <= 1'b0;
      dl.sts_good_inc  <= 1'b0;
      dl.open_inc      <= 1'b0;
      dl.open_good_inc <= 1'b0;
    end else begin
      dl.clear         <= ev.start_edge;  // stays aligned with same-edge events
      dl.rx_bytes_inc  <= ev.rx_fire ? keep_bytes(ev.rx_keep) : '0;
      dl.rx_pkt_inc    <= ev.rx_fire & ev.rx_last;
      dl.tx_bytes_inc  <= ev.tx_fire ? keep_bytes(ev.tx_keep) : '0;
      dl.tx_pkt_inc    <= ev.tx_fire & ev.tx_last;
      dl.sts_inc       <= ev.sts_fire;
      dl.sts_good_inc  <= ev.sts_fire & sts_ok;
      dl.open_inc      <= ev.open_fire;
      dl.open_good_inc <= ev.open_fire & open_ok;
    end
  end

endmodule

// ==== logic/run_control.sv ====
`timescale 1ns/1ps

// experiment window: running flag, done pulse, idle level, cycle count
module run_control (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  tcp_event_if.dst              ev,
  output logic                  ap_done,
  output logic                  ap_idle,
  output bench_pkg::cycle_cnt_t exec_cycles
);

  logic start_q;  // start edge, delayed to line up with the decode stage
  logic close_q;  // close handshake, same delay
  logic running;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      close_q <= 1'b0;
    end else begin
      start_q <= ev.start_edge;
      close_q <= ev.close_fire;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      running <= 1'b0;
      ap_done <= 1'b0;
      ap_idle <= 1'b1;
    end else begin
      ap_done <= close_q;  // one cycle, even when no window is open
      if (close_q) begin
        running <= 1'b0;   // close beats a same-cycle start
        ap_idle <= 1'b1;
      end else if (start_q) begin
        running <= 1'b1;
        ap_idle <= 1'b0;
      end
    end
  end

  // cleared by the start, then one per edge while the window is open
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      exec_cycles <= '0;
    end else if (start_q) begin
      exec_cycles <= '0;
    end else if (running) begin
      exec_cycles <= exec_cycles + 1'b1;
    end
  end

endmodule

// ==== logic/stat_accumulate.sv ====
`timescale 1ns/1ps

// stage 3: the statistics counters
// clear restarts from this cycle's increment so nothing at the start edge is lost
module stat_accumulate (
  input  logic                 ap_clk,
  input  logic                 ap_rst_n,
  tcp_delta_if.dst             dl,
  output bench_pkg::byte_cnt_t rx_bytes,
  output bench_pkg::byte_cnt_t tx_bytes,
  output bench_pkg::stat_cnt_t rx_pkts,
  output bench_pkg::stat_cnt_t tx_pkts,
  output bench_pkg::stat_cnt_t sts_total,
  output bench_pkg::stat_cnt_t sts_good,
  output bench_pkg::stat_cnt_t open_total,
  output bench_pkg::stat_cnt_t open_good
);

  // base value each counter adds to, zero on a restart
  bench_pkg::byte_cnt_t rx_bytes_base, tx_bytes_base;
  bench_pkg::stat_cnt_t rx_pkts_base, tx_pkts_base;
  bench_pkg::stat_cnt_t sts_total_base, sts_good_base;
  bench_pkg::stat_cnt_t open_total_base, open_good_base;

  assign rx_bytes_base   = dl.clear ? '0 : rx_bytes;
  assign tx_bytes_base   = dl.clear ? '0 : tx_bytes;
  assign rx_pkts_base    = dl.clear ? '0 : rx_pkts;
  assign tx_pkts_base    = dl.clear ? '0 : tx_pkts;
  assign sts_total_base  = dl.clear ? '0 : sts_total;
  assign sts_good_base   = dl.clear ? '0 : sts_good;
  assign open_total_base = dl.clear ? '0 : open_total;
  assign open_good_base  = dl.clear ? '0 : open_good;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rx_bytes   <= '0;
      tx_bytes   <= '0;
      rx_pkts    <= '0;
      tx_pkts    <= '0;
      sts_total  <= '0;
      sts_good   <= '0;
      open_total <= '0;
      open_good  <= '0;
    end else begin
      // byte increments are narrow, zero extend
      rx_bytes   <= rx_bytes_base + bench_pkg::byte_cnt_t'(dl.rx_bytes_inc);
      tx_bytes   <= tx_bytes_base + bench_pkg::byte_cnt_t'(dl.tx_bytes_inc);
      rx_pkts    <= rx_pkts_base + bench_pkg::stat_cnt_t'(dl.rx_pkt_inc);
      tx_pkts    <= tx_pkts_base + bench_pkg::stat_cnt_t'(dl.tx_pkt_inc);
      sts_total  <= sts_total_base + bench_pkg::stat_cnt_t'(dl.sts_inc);
      sts_good   <= sts_good_base + bench_pkg::stat_cnt_t'(dl.sts_good_inc);
      open_total <= open_total_base + bench_pkg::stat_cnt_t'(dl.open_inc);
      open_good  <= open_good_base + bench_pkg::stat_cnt_t'(dl.open_good_inc);
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_bench_monitor \
  -o tb_bench_monitor > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_bench_monitor > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

// ==== verif/bench_monitor_asserts.sv ====
`timescale 1ns/1ps

// done pulse shape and counter monotonicity on the monitor top
module bench_monitor_asserts (
  input logic                 ap_clk,
  input logic                 ap_rst_n,
  input logic                 ap_start,
  input logic                 ap_done,
  input logic                 ap_idle,
  input bench_pkg::byte_cnt_t rx_bytes,
  input bench_pkg::byte_cnt_t tx_bytes
);

  logic       start_prev;
  logic [2:0] rise_pipe;  // start edge history, bit 2 marks the cycle after the clear

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_prev <= 1'b0;
      rise_pipe  <= '0;
    end else begin
      start_prev <= ap_start;
      rise_pipe  <= {rise_pipe[1:0], ap_start & ~start_prev};
    end
  end

  done_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> !ap_done) else $error("ap_done stayed high for two cycles");

  done_idle: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> ap_idle) else $error("ap_idle low in the cycle after ap_done");

  rx_monotonic: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    (rx_bytes < $past(rx_bytes)) |-> rise_pipe[2]) else $error("rx_bytes went down");

  tx_monotonic: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    (tx_bytes < $past(tx_bytes)) |-> rise_pipe[2]) else $error("tx_bytes went down");

endmodule

bind bench_monitor_top bench_monitor_asserts i_bench_monitor_asserts (
  .ap_clk, .ap_rst_n, .ap_start, .ap_done, .ap_idle, .rx_bytes, .tx_bytes
);

// ==== verif/tb_bench_monitor.sv ====
`timescale 1ns/1ps

// random traffic against the statistics monitor, checked against a running model
module tb_bench_monitor;

  localparam int tb_bytes = 8;

  logic ap_clk, ap_rst_n, ap_start;
  logic rx_tvalid, rx_tready, rx_tlast, tx_tvalid, tx_tready, tx_tlast;
  logic [tb_bytes-1:0] rx_tkeep, tx_tkeep;
  logic tx_status_tvalid, tx_status_tready, open_status_tvalid, open_status_tready;
  bench_pkg::tx_status_t   tx_status_tdata;
  bench_pkg::open_status_t open_status_tdata;
  logic close_tvalid, close_tready, ap_done, ap_idle;
  bench_pkg::byte_cnt_t  rx_bytes, tx_bytes;
  bench_pkg::stat_cnt_t  rx_pkts, tx_pkts, sts_total, sts_good, open_total, open_good;
  bench_pkg::cycle_cnt_t exec_cycles;

  // model state
  bench_pkg::byte_cnt_t  exp_rx_bytes, exp_tx_bytes;
  bench_pkg::stat_cnt_t  exp_rx_pkts, exp_tx_pkts, exp_sts, exp_sts_good, exp_open, exp_open_good;
  bench_pkg::cycle_cnt_t exp_cycles;
  longint unsigned edge_cnt, start_at;  // edges since reset, edge of the last start sample
  logic start_prev, window_open;
  int   checks_done = 0;
  event check_req;

  bench_monitor_top #(.stream_bytes(tb_bytes)) i_bench_monitor_top (.*);

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;  // 125 MHz
  end

  // reference: one byte per set keep bit
  function automatic int keep_count(input logic [tb_bytes-1:0] keep);
    int n;
    n = 0;
    for (int i = 0; i < tb_bytes; i++) n += int'(keep[i]);
    return n;
  endfunction

  function automatic logic [tb_bytes-1:0] contiguous_keep(input int n);
    logic [tb_bytes-1:0] k;
    for (int i = 0; i < tb_bytes; i++) k[i] = (i < n);  // low n lanes
    return k;
  endfunction

  // model, clear on the start sample then add that same edge's beats
  always @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      {exp_rx_bytes, exp_tx_bytes} = '0;
      {exp_rx_pkts, exp_tx_pkts, exp_sts, exp_sts_good, exp_open, exp_open_good} = '0;
      exp_cycles = '0;
      edge_cnt = 0;
      start_at = 0;
      start_prev = 1'b0;
      window_open = 1'b0;
    end else begin
      edge_cnt++;
      if (ap_start && !start_prev) begin
        {exp_rx_bytes, exp_tx_bytes} = '0;
        {exp_rx_pkts, exp_tx_pkts, exp_sts, exp_sts_good, exp_open, exp_open_good} = '0;
        start_at = edge_cnt;
        window_open = 1'b1;
      end
      start_prev = ap_start;
      if (rx_tvalid && rx_tready) begin
        exp_rx_bytes += bench_pkg::byte_cnt_t'(keep_count(rx_tkeep));
        if (rx_tlast) exp_rx_pkts += 32'd1;
      end
      if (tx_tvalid && tx_tready) begin
        exp_tx_bytes += bench_pkg::byte_cnt_t'(keep_count(tx_tkeep));
        if (tx_tlast) exp_tx_pkts += 32'd1;
      end
      if (tx_status_tvalid && tx_status_tready) begin
        exp_sts += 32'd1;
        if (tx_status_tdata[bench_pkg::tx_err_hi:bench_pkg::tx_err_lo] == 2'b00)
          exp_sts_good += 32'd1;
      end
      if (open_status_tvalid && open_status_tready) begin
        exp_open += 32'd1;
        if (open_status_tdata[bench_pkg::open_success_bit]) exp_open_good += 32'd1;
      end
      if (close_tvalid && close_tready && window_open) begin
        exp_cycles = bench_pkg::cycle_cnt_t'(edge_cnt - start_at);  // start to close sample
        window_open = 1'b0;
      end
    end
  end

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test failed");
    $fatal(1, "wait timed out");
  endtask

  // comparing process, three quiet edges drain the pipeline first
  initial begin
    forever begin
      @(check_req);
      repeat (3) @(posedge ap_clk);
      @(negedge ap_clk);
      check_value("rx_bytes", 64'(rx_bytes), 64'(exp_rx_bytes));
      check_value("tx_bytes", 64'(tx_bytes), 64'(exp_tx_bytes));
      check_value("rx_pkts", 64'(rx_pkts), 64'(exp_rx_pkts));
      check_value("tx_pkts", 64'(tx_pkts), 64'(exp_tx_pkts));
      check_value("sts_total", 64'(sts_total), 64'(exp_sts));
      check_value("sts_good", 64'(sts_good), 64'(exp_sts_good));
      check_value("open_total", 64'(open_total), 64'(exp_open));
      check_value("open_good", 64'(open_good), 64'(exp_open_good));
      checks_done++;
    end
  end

  task automatic compare_counters();
    int target;
    int waited;
    target = checks_done + 1;
    waited = 0;
    -> check_req;
    while (checks_done < target) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 10) stop_on_timeout("counter compare never finished");
    end
  endtask

  task automatic idle_inputs();
    {ap_start, rx_tvalid, rx_tready, rx_tlast, tx_tvalid, tx_tready, tx_tlast} = '0;
    {rx_tkeep, tx_tkeep, tx_status_tvalid, tx_status_tready, tx_status_tdata} = '0;
    {open_status_tvalid, open_status_tready, open_status_tdata, close_tvalid, close_tready} = '0;
  endtask

  // random beats on every stream, ap_start high for the first start_cycles
  task automatic run_traffic(input int cycles, input int start_cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge ap_clk);
      ap_start = (i < start_cycles);
      rx_tvalid = ($urandom % 4) != 0;
      rx_tready = ($urandom % 3) != 0;
      rx_tkeep = contiguous_keep(1 + int'($urandom % tb_bytes));
      rx_tlast = ($urandom % 5) == 0;
      tx_tvalid = ($urandom % 4) != 0;
      tx_tready = ($urandom % 3) != 0;
      tx_tkeep = contiguous_keep(1 + int'($urandom % tb_bytes));
      tx_tlast = ($urandom % 5) == 0;
      tx_status_tvalid = ($urandom % 3) == 0;
      tx_status_tready = ($urandom % 2) == 0;
      tx_status_tdata = {$urandom, $urandom};  // error field zero one time in four
      open_status_tvalid = ($urandom % 3) == 0;
      open_status_tready = ($urandom % 2) == 0;
      open_status_tdata = 24'($urandom);
    end
    @(negedge ap_clk);
    idle_inputs();
  endtask

  // one accepted close, then the done pulse and the final cycle count
  task automatic close_window();
    int waited;
    waited = 0;
    close_tvalid = 1'b1;
    close_tready = 1'b1;
    @(negedge ap_clk);
    {close_tvalid, close_tready} = 2'b00;
    while (ap_done !== 1'b1) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 20) stop_on_timeout("ap_done did not pulse after the close");
    end
    check_value("ap_idle at done", 64'(ap_idle), 64'd1);
    check_value("exec_cycles", exec_cycles, exp_cycles);
    @(negedge ap_clk);
    check_value("ap_done after pulse", 64'(ap_done), 64'd0);
  endtask

  initial begin
    void'($urandom(22));
    idle_inputs();
    ap_rst_n = 1'b0;
    repeat (10) @(negedge ap_clk);
    ap_rst_n = 1'b1;
    check_value("ap_idle after reset", 64'(ap_idle), 64'd1);
    check_value("ap_done after reset", 64'(ap_done), 64'd0);
    check_value("exec_cycles after reset", exec_cycles, 64'd0);
    compare_counters();
    run_traffic(200, 3);  // first window
    compare_counters();
    check_value("ap_idle in window", 64'(ap_idle), 64'd0);
    close_window();
    run_traffic(60, 0);   // traffic between windows
    compare_counters();
    run_traffic(150, 2);  // restart drops the first window's totals
    compare_counters();
    close_window();
    compare_counters();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/bench_pkg.sv
logic/bench_if.sv
logic/event_capture.sv
logic/keep_decode.sv
logic/stat_accumulate.sv
logic/run_control.sv
logic/bench_monitor_top.sv
verif/bench_monitor_asserts.sv
verif/tb_bench_monitor.sv
